//--- src/pair_consts.svh
// Field and loop constants; LOOP_X must have its top bit set and FE_P must be prime
`ifndef PAIR_CONSTS_SVH
`define PAIR_CONSTS_SVH

// Field element width and modulus
`define FE_BITS 16
`define FE_P 65521

// Curve y^2 = x^3 + b
`define CURVE_B 4

// Loop constant, walked from bit LOOP_BITS-2 down to bit 0
`define LOOP_X 16'hD201
`define LOOP_BITS 16

// Cycles from request to response in fp_mul
`define MUL_LAT 3

`endif

//--- src/pair_pkg.sv
// Shared types and modular helpers; add/sub/dbl expect operands already below FE_P
`include "pair_consts.svh"

package pair_pkg;

  typedef logic [`FE_BITS-1:0] fe_t;

  typedef struct packed {
    fe_t x;
    fe_t y;
  } af_point_t;

  typedef struct packed {
    fe_t x;
    fe_t y;
    fe_t z;
  } jb_point_t;

  typedef enum logic {UNIT_DBL, UNIT_ADD} unit_tag_t;

  typedef struct packed {
    unit_tag_t  unit;
    logic [3:0] slot; // Temporary register index in the requester
  } mul_tag_t;

  typedef logic acc_tag_t; // 1 marks the square pass

  typedef struct packed {
    fe_t       f;
    jb_point_t t;
  } pair_res_t;

  function automatic fe_t add(fe_t a, fe_t b);
    logic [`FE_BITS:0] s;
    s = a + b;
    if (s >= `FE_P) s = s - `FE_P;
    return s[`FE_BITS-1:0];
  endfunction

  function automatic fe_t sub(fe_t a, fe_t b);
    logic [`FE_BITS:0] s;
    s = (a >= b) ? a - b : a + `FE_P - b; // Wrap below zero
    return s[`FE_BITS-1:0];
  endfunction

  function automatic fe_t dbl(fe_t a);
    return add(a, a);
  endfunction

endpackage

//--- src/fp_mul.sv
// Fixed latency of MUL_LAT cycles with no back-pressure; a request is taken every cycle it is valid
`timescale 1ns/1ps
`include "pair_consts.svh"

module fp_mul #(
  parameter type TAG_TYPE = logic
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_req_val,
  input  pair_pkg::fe_t   i_a,
  input  pair_pkg::fe_t   i_b,
  input  TAG_TYPE         i_tag,
  output logic            o_rsp_val,
  output pair_pkg::fe_t   o_prod,
  output TAG_TYPE         o_tag
);
  import pair_pkg::*;

  logic [2*`FE_BITS-1:0] prod_s1;
  fe_t                   red_s2;
  logic                  val_s1, val_s2;
  TAG_TYPE               tag_s1, tag_s2;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_s1    <= 1'b0;
      val_s2    <= 1'b0;
      o_rsp_val <= 1'b0;
    end else begin
      val_s1    <= i_req_val;
      val_s2    <= val_s1;
      o_rsp_val <= val_s2;
    end
  end

  always_ff @(posedge i_clk) begin
    prod_s1 <= i_a * i_b;                      // Full product
    tag_s1  <= i_tag;
    red_s2  <= fe_t'(prod_s1 % `FE_P);         // Reduce
    tag_s2  <= tag_s1;
    o_prod  <= red_s2;
    o_tag   <= tag_s2;
  end

  a_lat : assert property (@(posedge i_clk) disable iff (i_rst)
    i_req_val |-> ##(`MUL_LAT) o_rsp_val);

endmodule

//--- src/mul_share.sv
// Fixed priority to the doubling unit; grants are combinational and responses route by tag unit
`timescale 1ns/1ps
`include "pair_consts.svh"

module mul_share (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_dbl_req_val,
  input  pair_pkg::fe_t      i_dbl_a,
  input  pair_pkg::fe_t      i_dbl_b,
  input  logic [3:0]         i_dbl_slot,
  output logic               o_dbl_gnt,
  input  logic               i_add_req_val,
  input  pair_pkg::fe_t      i_add_a,
  input  pair_pkg::fe_t      i_add_b,
  input  logic [3:0]         i_add_slot,
  output logic               o_add_gnt,
  output logic               o_dbl_rsp_val,
  output logic               o_add_rsp_val,
  output pair_pkg::fe_t      o_rsp_prod,
  output logic [3:0]         o_rsp_slot,
  output logic               o_req_val,
  output pair_pkg::fe_t      o_a,
  output pair_pkg::fe_t      o_b,
  output pair_pkg::mul_tag_t o_tag,
  input  logic               i_rsp_val,
  input  pair_pkg::fe_t      i_prod,
  input  pair_pkg::mul_tag_t i_tag
);
  import pair_pkg::*;

  always_comb begin
    o_dbl_gnt = i_dbl_req_val;
    o_add_gnt = i_add_req_val && !i_dbl_req_val; // Loses to doubling
    o_req_val = i_dbl_req_val || i_add_req_val;
    if (i_dbl_req_val) begin
      o_a   = i_dbl_a;
      o_b   = i_dbl_b;
      o_tag = '{unit: UNIT_DBL, slot: i_dbl_slot};
    end else begin
      o_a   = i_add_a;
      o_b   = i_add_b;
      o_tag = '{unit: UNIT_ADD, slot: i_add_slot};
    end
  end

  // Response demux
  assign o_dbl_rsp_val = i_rsp_val && (i_tag.unit == UNIT_DBL);
  assign o_add_rsp_val = i_rsp_val && (i_tag.unit == UNIT_ADD);
  assign o_rsp_prod    = i_prod;
  assign o_rsp_slot    = i_tag.slot;

  // Each response goes back to the unit granted MUL_LAT cycles before
  a_rsp_route : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_dbl_rsp_val == $past(o_dbl_gnt, `MUL_LAT)) &&
    (o_add_rsp_val == $past(o_add_gnt, `MUL_LAT)));

endmodule

//--- src/miller_ctrl.sv
// One pairing at a time; T starts as Q with Z = 1 and the top loop bit is implied
`timescale 1ns/1ps
`include "pair_consts.svh"

module miller_ctrl (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  output logic                o_rdy,
  input  pair_pkg::af_point_t i_p,
  input  pair_pkg::af_point_t i_q,
  input  logic                i_out_taken,
  output logic                o_dbl_start,
  output logic                o_add_start,
  output pair_pkg::jb_point_t o_t,
  output pair_pkg::af_point_t o_p,
  output pair_pkg::af_point_t o_q,
  input  logic                i_dbl_done,
  input  pair_pkg::jb_point_t i_dbl_t,
  input  pair_pkg::fe_t       i_dbl_line,
  input  logic                i_add_done,
  input  pair_pkg::jb_point_t i_add_t,
  input  pair_pkg::fe_t       i_add_line,
  output logic                o_acc_start,
  output logic                o_acc_sq,
  output pair_pkg::fe_t       o_line,
  input  logic                i_acc_done,
  output logic                o_fin,
  output pair_pkg::jb_point_t o_t_final
);
  import pair_pkg::*;

  typedef enum logic [2:0] {IDLE, DBL, ACC_D, ADD, ACC_A, DONE} state_t;

  localparam logic [`LOOP_BITS-1:0] LOOP = `LOOP_X;

  state_t                         state;
  logic [$clog2(`LOOP_BITS)-1:0]  bit_cnt;
  logic                           dbl_busy, add_busy;

  assign o_t       = o_t_final;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= IDLE;
      o_rdy       <= 1'b0;
      o_dbl_start <= 1'b0;
      o_add_start <= 1'b0;
      o_acc_start <= 1'b0;
      o_fin       <= 1'b0;
      dbl_busy    <= 1'b0;
      add_busy    <= 1'b0;
    end else begin
      o_dbl_start <= 1'b0;
      o_add_start <= 1'b0;
      o_acc_start <= 1'b0;
      o_fin       <= 1'b0;
      if (o_dbl_start) dbl_busy <= 1'b1;
      if (i_dbl_done) dbl_busy <= 1'b0;
      if (o_add_start) add_busy <= 1'b1;
      if (i_add_done) add_busy <= 1'b0;
      case (state)
        IDLE: begin
          o_rdy <= 1'b1;
          if (i_val && o_rdy) begin
            o_rdy       <= 1'b0;
            o_dbl_start <= 1'b1;
            state       <= DBL;
          end
        end
        DBL: if (i_dbl_done) begin
          o_acc_start <= 1'b1;
          state       <= ACC_D;
        end
        ACC_D: if (i_acc_done) begin
          if (LOOP[bit_cnt]) begin
            o_add_start <= 1'b1;
            state       <= ADD;
          end else if (bit_cnt == 0) begin
            o_fin <= 1'b1;
            state <= DONE;
          end else begin
            o_dbl_start <= 1'b1;
            state       <= DBL;
          end
        end
        ADD: if (i_add_done) begin
          o_acc_start <= 1'b1;
          state       <= ACC_A;
        end
        ACC_A: if (i_acc_done) begin
          if (bit_cnt == 0) begin
            o_fin <= 1'b1;
            state <= DONE;
          end else begin
            o_dbl_start <= 1'b1;
            state       <= DBL;
          end
        end
        DONE: if (i_out_taken) begin
          o_rdy <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operands, T and the bit counter
  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_val && o_rdy) begin
      o_p       <= i_p;
      o_q       <= i_q;
      o_t_final <= '{x: i_q.x, y: i_q.y, z: fe_t'(1)};
      bit_cnt   <= ($clog2(`LOOP_BITS))'(`LOOP_BITS - 2);
    end
    if (state == DBL && i_dbl_done) begin
      o_t_final <= i_dbl_t;
      o_line    <= i_dbl_line;
      o_acc_sq  <= 1'b1;
    end
    if (state == ADD && i_add_done) begin
      o_t_final <= i_add_t;
      o_line    <= i_add_line;
      o_acc_sq  <= 1'b0;
    end
    if ((state == ACC_D && i_acc_done && !LOOP[bit_cnt]) || (state == ACC_A && i_acc_done))
      bit_cnt <= bit_cnt - 1'b1;
  end

  a_dbl_idle : assert property (@(posedge i_clk) disable iff (i_rst)
    o_dbl_start |-> !dbl_busy && !add_busy);
  a_add_idle : assert property (@(posedge i_clk) disable iff (i_rst)
    o_add_start |-> !add_busy && !dbl_busy);

endmodule

//--- src/miller_dbl.sv
// Jacobian doubling with a = 0; degenerate points are not special-cased
`timescale 1ns/1ps

module miller_dbl (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  pair_pkg::jb_point_t i_t,
  input  pair_pkg::af_point_t i_p,
  output logic                o_done,
  output pair_pkg::jb_point_t o_t,
  output pair_pkg::fe_t       o_line,
  output logic                o_req_val,
  output pair_pkg::fe_t       o_a,
  output pair_pkg::fe_t       o_b,
  output logic [3:0]          o_slot,
  input  logic                i_gnt,
  input  logic                i_rsp_val,
  input  pair_pkg::fe_t       i_prod,
  input  logic [3:0]          i_slot
);
  import pair_pkg::*;

  localparam int N = 13;

  jb_point_t    t;
  af_point_t    p;
  fe_t          tmp [N];
  fe_t          op_a [N];
  fe_t          op_b [N];
  logic [N-1:0] rdy, issued, ok;
  logic         busy, any;
  fe_t          e, d, x3, z3, xb;

  // Slots 0 A, 1 B, 2 C, 3 (X+B)^2, 4 ZZ, 5 F, 6 YZ, 7 E(D-X3), 8..12 line terms
  always_comb begin
    e  = add(dbl(tmp[0]), tmp[0]);
    d  = dbl(sub(sub(tmp[3], tmp[0]), tmp[2]));
    x3 = sub(tmp[5], dbl(d));
    z3 = dbl(tmp[6]);
    xb = add(t.x, tmp[1]);
    op_a[0]  = t.x;     op_b[0]  = t.x;         ok[0]  = 1'b1;
    op_a[1]  = t.y;     op_b[1]  = t.y;         ok[1]  = 1'b1;
    op_a[2]  = tmp[1];  op_b[2]  = tmp[1];      ok[2]  = rdy[1];
    op_a[3]  = xb;      op_b[3]  = xb;          ok[3]  = rdy[1];
    op_a[4]  = t.z;     op_b[4]  = t.z;         ok[4]  = 1'b1;
    op_a[5]  = e;       op_b[5]  = e;           ok[5]  = rdy[0];
    op_a[6]  = t.y;     op_b[6]  = t.z;         ok[6]  = 1'b1;
    op_a[7]  = e;       op_b[7]  = sub(d, x3);  ok[7]  = &{rdy[0], rdy[2], rdy[3], rdy[5]};
    op_a[8]  = z3;      op_b[8]  = tmp[4];      ok[8]  = rdy[6] && rdy[4];
    op_a[9]  = tmp[8];  op_b[9]  = p.y;         ok[9]  = rdy[8];
    op_a[10] = e;       op_b[10] = tmp[4];      ok[10] = rdy[0] && rdy[4];
    op_a[11] = tmp[10]; op_b[11] = p.x;         ok[11] = rdy[10];
    op_a[12] = e;       op_b[12] = t.x;         ok[12] = rdy[0];
  end

  // Lowest ready slot goes first
  always_comb begin
    any    = 1'b0;
    o_slot = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (ok[k] && !issued[k]) begin
        any    = 1'b1;
        o_slot = 4'(k);
      end
    end
    o_req_val = busy && any;
    o_a       = op_a[o_slot];
    o_b       = op_b[o_slot];
  end

  always_comb begin
    o_t.x  = x3;
    o_t.y  = sub(tmp[7], dbl(dbl(dbl(tmp[2])))); // Minus 8C
    o_t.z  = z3;
    o_line = add(sub(tmp[9], tmp[11]), sub(tmp[12], dbl(tmp[1])));
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
      issued <= '0;
      rdy    <= '0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy   <= 1'b1;
        issued <= '0;
        rdy    <= '0;
      end else if (busy) begin
        if (o_req_val && i_gnt) issued[o_slot] <= 1'b1;
        if (i_rsp_val) rdy[i_slot] <= 1'b1;
        if (&rdy) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      t <= i_t;
      p <= i_p;
    end
    if (i_rsp_val) tmp[i_slot] <= i_prod;
  end

endmodule

//--- src/miller_add.sv
// Mixed Jacobian plus affine Q; H = 0 is not detected and gives Z3 = 0
`timescale 1ns/1ps

module miller_add (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  pair_pkg::jb_point_t i_t,
  input  pair_pkg::af_point_t i_p,
  input  pair_pkg::af_point_t i_q,
  output logic                o_done,
  output pair_pkg::jb_point_t o_t,
  output pair_pkg::fe_t       o_line,
  output logic                o_req_val,
  output pair_pkg::fe_t       o_a,
  output pair_pkg::fe_t       o_b,
  output logic [3:0]          o_slot,
  input  logic                i_gnt,
  input  logic                i_rsp_val,
  input  pair_pkg::fe_t       i_prod,
  input  logic [3:0]          i_slot
);
  import pair_pkg::*;

  localparam int N = 15;

  jb_point_t    t;
  af_point_t    p, q;
  fe_t          tmp [N];
  fe_t          op_a [N];
  fe_t          op_b [N];
  logic [N-1:0] rdy, issued, ok;
  logic         busy, any;
  fe_t          h, r, x3;

  // Slots 0 ZZ, 1 U, 2 ZZZ, 3 S, 4 HH, 5 HHH, 6 XHH, 7 RR, 8 Z3, 9 R(XHH-X3), 10 Y*HHH
  always_comb begin
    h  = sub(tmp[1], t.x);
    r  = sub(tmp[3], t.y);
    x3 = sub(sub(tmp[7], tmp[5]), dbl(tmp[6]));
    op_a[0]  = t.z;     op_b[0]  = t.z;              ok[0]  = 1'b1;
    op_a[1]  = q.x;     op_b[1]  = tmp[0];           ok[1]  = rdy[0];
    op_a[2]  = tmp[0];  op_b[2]  = t.z;              ok[2]  = rdy[0];
    op_a[3]  = q.y;     op_b[3]  = tmp[2];           ok[3]  = rdy[2];
    op_a[4]  = h;       op_b[4]  = h;                ok[4]  = rdy[1];
    op_a[5]  = tmp[4];  op_b[5]  = h;                ok[5]  = rdy[4];
    op_a[6]  = t.x;     op_b[6]  = tmp[4];           ok[6]  = rdy[4];
    op_a[7]  = r;       op_b[7]  = r;                ok[7]  = rdy[3];
    op_a[8]  = t.z;     op_b[8]  = h;                ok[8]  = rdy[1];
    op_a[9]  = r;       op_b[9]  = sub(tmp[6], x3);  ok[9]  = &{rdy[5], rdy[6], rdy[7]};
    op_a[10] = t.y;     op_b[10] = tmp[5];           ok[10] = rdy[5];
    op_a[11] = tmp[8];  op_b[11] = p.y;              ok[11] = rdy[8];
    op_a[12] = r;       op_b[12] = p.x;              ok[12] = rdy[3];
    op_a[13] = r;       op_b[13] = q.x;              ok[13] = rdy[3];
    op_a[14] = tmp[8];  op_b[14] = q.y;              ok[14] = rdy[8];
  end

  always_comb begin
    any    = 1'b0;
    o_slot = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (ok[k] && !issued[k]) begin
        any    = 1'b1;
        o_slot = 4'(k);
      end
    end
    o_req_val = busy && any;
    o_a       = op_a[o_slot];
    o_b       = op_b[o_slot];
  end

  always_comb begin
    o_t.x  = x3;
    o_t.y  = sub(tmp[9], tmp[10]);
    o_t.z  = tmp[8];
    o_line = sub(add(sub(tmp[11], tmp[12]), tmp[13]), tmp[14]);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
      issued <= '0;
      rdy    <= '0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy   <= 1'b1;
        issued <= '0;
        rdy    <= '0;
      end else if (busy) begin
        if (o_req_val && i_gnt) issued[o_slot] <= 1'b1;
        if (i_rsp_val) rdy[i_slot] <= 1'b1;
        if (&rdy) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      t <= i_t;
      p <= i_p;
      q <= i_q;
    end
    if (i_rsp_val) tmp[i_slot] <= i_prod;
  end

endmodule

//--- src/f_accum.sv
// f returns to one after reset and after each result is taken; output holds while i_rdy is low
`timescale 1ns/1ps

module f_accum (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic                i_sq,
  input  pair_pkg::fe_t       i_line,
  output logic                o_done,
  input  logic                i_fin,
  input  pair_pkg::jb_point_t i_t_final,
  output logic                o_val,
  input  logic                i_rdy,
  output pair_pkg::pair_res_t o_res,
  output logic                o_out_taken
);
  import pair_pkg::*;

  fe_t      f, line;
  logic     req_val, rsp_val;
  fe_t      req_a, req_b, prod;
  acc_tag_t req_tag, rsp_tag;

  assign o_out_taken = o_val && i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      req_val <= 1'b0;
      o_done  <= 1'b0;
      o_val   <= 1'b0;
      f       <= fe_t'(1);
    end else begin
      req_val <= 1'b0;
      o_done  <= 1'b0;
      if (i_start) begin
        req_val <= 1'b1;
        req_a   <= f;
        req_b   <= i_sq ? f : i_line;
        req_tag <= i_sq;
      end
      if (rsp_val) begin
        f <= prod;
        if (rsp_tag) begin  // Square done, now the line product
          req_val <= 1'b1;
          req_a   <= prod;
          req_b   <= line;
          req_tag <= 1'b0;
        end else begin
          o_done <= 1'b1;
        end
      end
      if (i_fin) begin
        o_val <= 1'b1;
        o_res <= '{f: f, t: i_t_final};
      end else if (o_out_taken) begin
        o_val <= 1'b0;
        f     <= fe_t'(1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) line <= i_line;
  end

  fp_mul #(.TAG_TYPE(acc_tag_t)) u_mul (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req_val (req_val),
    .i_a       (req_a),
    .i_b       (req_b),
    .i_tag     (req_tag),
    .o_rsp_val (rsp_val),
    .o_prod    (prod),
    .o_tag     (rsp_tag)
  );

endmodule

//--- src/pair_engine.sv
// Scaled Miller loop over a 16-bit prime field; no final exponentiation, one pairing in flight
`timescale 1ns/1ps

module pair_engine (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  output logic                o_rdy,
  input  pair_pkg::af_point_t i_p,
  input  pair_pkg::af_point_t i_q,
  output logic                o_val,
  input  logic                i_rdy,
  output pair_pkg::pair_res_t o_res
);
  import pair_pkg::*;

  logic      dbl_start, add_start, dbl_done, add_done;
  logic      acc_start, acc_sq, acc_done, fin, out_taken;
  jb_point_t t_cur, dbl_t, add_t, t_final;
  af_point_t p_reg, q_reg;
  fe_t       dbl_line, add_line, line;
  logic      dbl_req, add_req, dbl_gnt, add_gnt, dbl_rsp, add_rsp;
  fe_t       dbl_a, dbl_b, add_a, add_b, rsp_prod;
  logic [3:0] dbl_slot, add_slot, rsp_slot;
  logic      mul_req, mul_rsp;
  fe_t       mul_a, mul_b, mul_prod;
  mul_tag_t  mul_tag_i, mul_tag_o;

  miller_ctrl u_ctrl (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_val (i_val), .o_rdy (o_rdy), .i_p (i_p), .i_q (i_q),
    .i_out_taken (out_taken),
    .o_dbl_start (dbl_start), .o_add_start (add_start),
    .o_t (t_cur), .o_p (p_reg), .o_q (q_reg),
    .i_dbl_done (dbl_done), .i_dbl_t (dbl_t), .i_dbl_line (dbl_line),
    .i_add_done (add_done), .i_add_t (add_t), .i_add_line (add_line),
    .o_acc_start (acc_start), .o_acc_sq (acc_sq), .o_line (line),
    .i_acc_done (acc_done), .o_fin (fin), .o_t_final (t_final)
  );

  miller_dbl u_dbl (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (dbl_start),
    .i_t (t_cur), .i_p (p_reg),
    .o_done (dbl_done), .o_t (dbl_t), .o_line (dbl_line),
    .o_req_val (dbl_req), .o_a (dbl_a), .o_b (dbl_b), .o_slot (dbl_slot), .i_gnt (dbl_gnt),
    .i_rsp_val (dbl_rsp), .i_prod (rsp_prod), .i_slot (rsp_slot)
  );

  miller_add u_add (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (add_start),
    .i_t (t_cur), .i_p (p_reg), .i_q (q_reg),
    .o_done (add_done), .o_t (add_t), .o_line (add_line),
    .o_req_val (add_req), .o_a (add_a), .o_b (add_b), .o_slot (add_slot), .i_gnt (add_gnt),
    .i_rsp_val (add_rsp), .i_prod (rsp_prod), .i_slot (rsp_slot)
  );

  mul_share u_share (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_dbl_req_val (dbl_req), .i_dbl_a (dbl_a), .i_dbl_b (dbl_b),
    .i_dbl_slot (dbl_slot), .o_dbl_gnt (dbl_gnt),
    .i_add_req_val (add_req), .i_add_a (add_a), .i_add_b (add_b),
    .i_add_slot (add_slot), .o_add_gnt (add_gnt),
    .o_dbl_rsp_val (dbl_rsp), .o_add_rsp_val (add_rsp),
    .o_rsp_prod (rsp_prod), .o_rsp_slot (rsp_slot),
    .o_req_val (mul_req), .o_a (mul_a), .o_b (mul_b), .o_tag (mul_tag_i),
    .i_rsp_val (mul_rsp), .i_prod (mul_prod), .i_tag (mul_tag_o)
  );

  fp_mul #(.TAG_TYPE(mul_tag_t)) u_mul (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_req_val (mul_req), .i_a (mul_a), .i_b (mul_b), .i_tag (mul_tag_i),
    .o_rsp_val (mul_rsp), .o_prod (mul_prod), .o_tag (mul_tag_o)
  );

  f_accum u_acc (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_start (acc_start), .i_sq (acc_sq), .i_line (line), .o_done (acc_done),
    .i_fin (fin), .i_t_final (t_final),
    .o_val (o_val), .i_rdy (i_rdy), .o_res (o_res), .o_out_taken (out_taken)
  );

endmodule

//--- sim/pair_model.svh
// Reference Miller loop; include inside a module that imports pair_pkg, inputs must be below FE_P
`ifndef PAIR_MODEL_SVH
`define PAIR_MODEL_SVH

// Field arithmetic on wide integers, reduced with %
function automatic fe_t add_mod(fe_t a, fe_t b);
  longint s;
  s = (longint'(a) + longint'(b)) % `FE_P;
  return fe_t'(s);
endfunction

function automatic fe_t sub_mod(fe_t a, fe_t b);
  longint s;
  s = (longint'(a) + `FE_P - longint'(b)) % `FE_P; // Lift by p before the difference
  return fe_t'(s);
endfunction

function automatic fe_t mul_mod(fe_t a, fe_t b);
  longint s;
  s = (longint'(a) * longint'(b)) % `FE_P;
  return fe_t'(s);
endfunction

// Tangent step with a = 0; the curve constant b does not enter these formulas
function automatic void double_step(input jb_point_t t, input af_point_t p,
                                    output jb_point_t t_next, output fe_t line);
  fe_t a, b, c, xb, d, e, zz, x3, y3, z3;
  a  = mul_mod(t.x, t.x);
  b  = mul_mod(t.y, t.y);
  c  = mul_mod(b, b);
  xb = add_mod(t.x, b);
  d  = mul_mod(fe_t'(2), sub_mod(sub_mod(mul_mod(xb, xb), a), c));
  e  = mul_mod(fe_t'(3), a);
  zz = mul_mod(t.z, t.z);
  x3 = sub_mod(mul_mod(e, e), mul_mod(fe_t'(2), d));
  y3 = sub_mod(mul_mod(e, sub_mod(d, x3)), mul_mod(fe_t'(8), c));
  z3 = mul_mod(fe_t'(2), mul_mod(t.y, t.z));
  t_next = '{x: x3, y: y3, z: z3};
  line = add_mod(sub_mod(mul_mod(mul_mod(z3, zz), p.y), mul_mod(mul_mod(e, zz), p.x)),
                 sub_mod(mul_mod(e, t.x), mul_mod(fe_t'(2), b)));
endfunction

// Chord step, T plus affine Q
function automatic void add_step(input jb_point_t t, input af_point_t q, input af_point_t p,
                                 output jb_point_t t_next, output fe_t line);
  fe_t zz, u, s, h, r, hh, hhh, xhh, x3, y3, z3;
  zz  = mul_mod(t.z, t.z);
  u   = mul_mod(q.x, zz);
  s   = mul_mod(mul_mod(q.y, zz), t.z);
  h   = sub_mod(u, t.x);
  r   = sub_mod(s, t.y);
  hh  = mul_mod(h, h);
  hhh = mul_mod(hh, h);
  xhh = mul_mod(t.x, hh);
  x3  = sub_mod(sub_mod(mul_mod(r, r), hhh), mul_mod(fe_t'(2), xhh));
  y3  = sub_mod(mul_mod(r, sub_mod(xhh, x3)), mul_mod(t.y, hhh));
  z3  = mul_mod(t.z, h);
  t_next = '{x: x3, y: y3, z: z3};
  line = sub_mod(add_mod(sub_mod(mul_mod(z3, p.y), mul_mod(r, p.x)), mul_mod(r, q.x)),
                 mul_mod(z3, q.y));
endfunction

// Full loop from the bit below the top bit down to bit 0
function automatic pair_res_t miller_loop(af_point_t p, af_point_t q);
  logic [`LOOP_BITS-1:0] x;
  jb_point_t             t, t_next;
  fe_t                   f, line;
  pair_res_t             res;
  x = `LOOP_X;
  t = '{x: q.x, y: q.y, z: fe_t'(1)};
  f = fe_t'(1);
  for (int i = `LOOP_BITS - 2; i >= 0; i--) begin
    double_step(t, p, t_next, line);
    t = t_next;
    f = mul_mod(mul_mod(f, f), line);
    if (x[i]) begin
      add_step(t, q, p, t_next, line);
      t = t_next;
      f = mul_mod(f, line);
    end
  end
  res = '{f: f, t: t};
  return res;
endfunction

`endif

//--- sim/tb_pair_engine.sv
// Drives 2 edge and 40 random vectors through pair_engine with random back-pressure
`timescale 1ns/1ps
`include "pair_consts.svh"

module tb_pair_engine;
  import pair_pkg::*;

  `include "pair_model.svh"

  localparam int NUM_RANDOM     = 40;
  localparam int NUM_VEC        = NUM_RANDOM + 2;
  localparam int TIMEOUT_CYCLES = NUM_VEC * (`LOOP_BITS * 200) + 1000;

  logic      i_clk = 1'b0;
  logic      i_rst;
  logic      i_val;
  logic      o_rdy;
  af_point_t i_p;
  af_point_t i_q;
  logic      o_val;
  logic      i_rdy;
  pair_res_t o_res;

  int checks = 0;
  int errors = 0;
  int cycles = 0;

  pair_engine UUT (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .i_p   (i_p),
    .i_q   (i_q),
    .o_val (o_val),
    .i_rdy (i_rdy),
    .o_res (o_res)
  );

  always #20 i_clk = ~i_clk; // 40 ns period

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the engine gave no result within %0d cycles", cycles);
      $display("Summary: %0d checks, %0d errors", checks, errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t ns %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_fe(input string name, input fe_t exp, input fe_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_point(input string name, input jb_point_t exp, input jb_point_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t ns %s expected (%h,%h,%h) got (%h,%h,%h)", $time, name,
               exp.x, exp.y, exp.z, act.x, act.y, act.z);
    end
  endtask

  function automatic fe_t rand_fe();
    return fe_t'($urandom % `FE_P);
  endfunction

  function automatic af_point_t rand_point();
    af_point_t pt;
    pt.x = rand_fe();
    pt.y = rand_fe();
    return pt;
  endfunction

  // Called at a falling edge; returns at the falling edge where the result is released
  task automatic run_vector(input af_point_t p, input af_point_t q);
    pair_res_t exp_res;
    int        gap;
    int        stall;
    exp_res = miller_loop(p, q);
    gap     = $urandom % 3;
    stall   = $urandom % 6;
    @(negedge i_clk);
    i_rdy = 1'b0;
    check_flag("o_val", 1'b0, o_val);
    check_flag("o_rdy", 1'b1, o_rdy);
    repeat (gap) begin  // Idle with i_val low, nothing may be taken
      @(negedge i_clk);
      check_flag("o_rdy", 1'b1, o_rdy);
      check_flag("o_val", 1'b0, o_val);
    end
    i_val = 1'b1;
    i_p   = p;
    i_q   = q;
    @(negedge i_clk);
    while (o_val !== 1'b1) begin
      check_flag("o_rdy", 1'b0, o_rdy);
      i_val = ($urandom % 2) == 1;   // Junk offers while busy
      i_p   = rand_point();
      i_q   = rand_point();
      @(negedge i_clk);
    end
    i_val = 1'b0;
    check_fe("o_res.f", exp_res.f, o_res.f);
    check_point("o_res.t", exp_res.t, o_res.t);
    repeat (stall) begin
      i_val = ($urandom % 2) == 1;
      i_p   = rand_point();
      i_q   = rand_point();
      @(negedge i_clk);
      check_flag("o_val", 1'b1, o_val);
      check_flag("o_rdy", 1'b0, o_rdy);
      check_fe("o_res.f", exp_res.f, o_res.f);
      check_point("o_res.t", exp_res.t, o_res.t);
    end
    i_val = 1'b0;
    i_rdy = 1'b1;  // Taken on the next rising edge
  endtask

  initial begin
    af_point_t zero_pt;
    af_point_t top_pt;
    void'($urandom(7876));
    i_rst   = 1'b1;
    i_val   = 1'b0;
    i_p     = '0;
    i_q     = '0;
    i_rdy   = 1'b0;
    zero_pt = '0;
    top_pt.x = fe_t'(`FE_P - 1);
    top_pt.y = fe_t'(`FE_P - 1);
    repeat (16) @(negedge i_clk);
    check_flag("o_val", 1'b0, o_val);
    check_flag("o_rdy", 1'b0, o_rdy);
    i_rst = 1'b0;

    // Wrap-around corners of modular add and subtract
    run_vector(zero_pt, top_pt);
    run_vector(top_pt, zero_pt);
    for (int n = 0; n < NUM_RANDOM; n++) begin
      run_vector(rand_point(), rand_point());
    end

    @(negedge i_clk);
    i_rdy = 1'b0;
    check_flag("o_val", 1'b0, o_val);
    check_flag("o_rdy", 1'b1, o_rdy);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
+incdir+sim
src/pair_pkg.sv
src/fp_mul.sv
src/mul_share.sv
src/miller_ctrl.sv
src/miller_dbl.sv
src/miller_add.sv
src/f_accum.sv
src/pair_engine.sv
sim/tb_pair_engine.sv

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, and fail if the log reports errors
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_pair_engine -f vlog.f -Mdir obj_dir
./obj_dir/Vtb_pair_engine | tee sim.log
if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
